// File: logic/conv_pkg.sv
package conv_pkg;

  localparam int N_CH      = 4;   // input channels
  localparam int ROW_PIX   = 12;  // pixels per image row
  localparam int PAD_PIX   = 14;  // row plus one zero pixel each side
  localparam int PIX_W     = 8;
  localparam int WGT_W     = 4;   // signed weights
  localparam int K_ROWS    = 3;
  localparam int K_TAPS    = 3;
  localparam int IN_ROWS   = 8;   // rows per frame
  localparam int OUT_ROWS  = 6;   // no vertical padding
  localparam int ROW_AW    = 3;
  localparam int PSUM_W    = 18;  // 36 products of u8 x s4 plus headroom
  localparam int ACT_SHIFT = 4;

  // last read issue to falling busy: read, tag align, stage 1, stage 2, relu
  localparam int DRAIN_CYC = 5;

  // one input row, pixel 0 sits in the low byte of each channel
  typedef struct packed {
    logic [N_CH-1:0][ROW_PIX-1:0][PIX_W-1:0] ch;
  } pixel_row_t;

  // same row with zero pixels at index 0 and PAD_PIX-1
  typedef struct packed {
    logic [N_CH-1:0][PAD_PIX-1:0][PIX_W-1:0] ch;
  } padded_row_t;

  // tap 0 multiplies the left neighbour, tap 2 the right one
  typedef struct packed {
    logic [K_TAPS-1:0][N_CH-1:0][WGT_W-1:0] tap;  // two's complement
  } kernel_row_t;

  typedef kernel_row_t [K_ROWS-1:0] kernel_t;  // index 0 is the top kernel row

  typedef struct packed {
    logic       valid;
    logic [1:0] krow;   // kernel row for this image row
    logic       first;  // restart accumulation
    logic       last;   // output row complete
  } mac_tag_t;

  typedef struct packed {
    logic [ROW_PIX-1:0][PSUM_W-1:0] sum;  // two's complement per lane
  } psum_row_t;

  typedef struct packed {
    logic [ROW_PIX-1:0][PIX_W-1:0] pix;
  } act_row_t;

endpackage

// File: logic/row_store.sv
`timescale 1ns/1ps

module row_store (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          din_valid,
  input  conv_pkg::pixel_row_t          din,
  input  logic                          busy,
  input  logic                          frame_start,
  input  logic [conv_pkg::ROW_AW-1:0]   rd_addr,
  output conv_pkg::pixel_row_t          rd_data
);

  conv_pkg::pixel_row_t        mem [conv_pkg::IN_ROWS];
  logic [conv_pkg::ROW_AW-1:0] wr_ptr;
  logic                        wr_en;

  assign wr_en = din_valid && !busy;  // frame is frozen while processing

  // write pointer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (frame_start) begin
      wr_ptr <= '0;  // next frame fills from row 0
    end else if (wr_en) begin
      wr_ptr <= wr_ptr + 1'b1;  // wraps after IN_ROWS rows
    end
  end

  // row memory
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  // one cycle read, runs every cycle
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: logic/window_sequencer.sv
`timescale 1ns/1ps

module window_sequencer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          frame_end,
  input  conv_pkg::pixel_row_t          rd_data,
  output logic [conv_pkg::ROW_AW-1:0]   rd_addr,
  output logic                          frame_start,
  output logic                          busy,
  output conv_pkg::padded_row_t         row_pad,
  output conv_pkg::mac_tag_t            tag
);

  logic [conv_pkg::ROW_AW-1:0] out_row;
  logic [1:0]                  k_row;
  logic                        running;   // read issue phase
  logic [2:0]                  drain_cnt;
  logic                        last_rd;
  conv_pkg::mac_tag_t          iss_tag;   // tag of the read issued this cycle

  assign frame_start = frame_end && !busy;  // frame_end ignored while busy
  assign last_rd     = running && (out_row == 3'(conv_pkg::OUT_ROWS - 1))
                       && (k_row == 2'(conv_pkg::K_ROWS - 1));

  // output row / kernel row walk, one read per cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running   <= 1'b0;
      busy      <= 1'b0;
      out_row   <= '0;
      k_row     <= '0;
      drain_cnt <= '0;
      rd_addr   <= '0;
      iss_tag   <= '0;
    end else begin
      iss_tag.valid <= 1'b0;
      if (frame_start) begin
        running <= 1'b1;
        busy    <= 1'b1;
        out_row <= '0;
        k_row   <= '0;
      end else if (running) begin
        rd_addr       <= out_row + {1'b0, k_row};  // image row r+k
        iss_tag.valid <= 1'b1;
        iss_tag.krow  <= k_row;
        iss_tag.first <= (k_row == 2'd0);
        iss_tag.last  <= (k_row == 2'(conv_pkg::K_ROWS - 1));
        if (k_row == 2'(conv_pkg::K_ROWS - 1)) begin
          k_row   <= '0;
          out_row <= out_row + 1'b1;
        end else begin
          k_row <= k_row + 1'b1;
        end
        if (last_rd) begin
          running   <= 1'b0;
          drain_cnt <= 3'(conv_pkg::DRAIN_CYC);  // wait for pipeline to empty
        end
      end else if (drain_cnt != '0) begin
        drain_cnt <= drain_cnt - 1'b1;
        if (drain_cnt == 3'd1) begin
          busy <= 1'b0;  // last dout_valid is leaving now
        end
      end
    end
  end

  // tag follows the registered read by one cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag <= '0;
    end else begin
      tag <= iss_tag;
    end
  end

  // horizontal zero padding on every channel
  always_comb begin
    for (int c = 0; c < conv_pkg::N_CH; c++) begin
      row_pad.ch[c] = {{conv_pkg::PIX_W{1'b0}}, rd_data.ch[c], {conv_pkg::PIX_W{1'b0}}};
    end
  end

endmodule

// File: logic/conv_row_mac.sv
`timescale 1ns/1ps

module conv_row_mac (
  input  logic                   clk,
  input  logic                   rst_n,
  input  conv_pkg::padded_row_t  row_pad,
  input  conv_pkg::mac_tag_t     tag,
  input  conv_pkg::kernel_t      weights,
  output conv_pkg::psum_row_t    psum,
  output logic                   psum_valid
);

  conv_pkg::kernel_row_t              krow_w;
  logic signed [conv_pkg::PSUM_W-1:0] row_sum [conv_pkg::ROW_PIX];
  logic signed [conv_pkg::PSUM_W-1:0] s1_sum  [conv_pkg::ROW_PIX];
  logic signed [conv_pkg::PSUM_W-1:0] acc     [conv_pkg::ROW_PIX];
  logic signed [conv_pkg::PSUM_W-1:0] acc_nxt [conv_pkg::ROW_PIX];
  conv_pkg::mac_tag_t                 s1_tag;

  // 3 taps x 4 channels per output position
  always_comb begin
    krow_w = weights[tag.krow];
    for (int x = 0; x < conv_pkg::ROW_PIX; x++) begin
      row_sum[x] = '0;
      for (int t = 0; t < conv_pkg::K_TAPS; t++) begin
        for (int c = 0; c < conv_pkg::N_CH; c++) begin
          row_sum[x] = row_sum[x]
                       + $signed({1'b0, row_pad.ch[c][x+t]})  // pixel is unsigned
                       * $signed(krow_w.tap[t][c]);
        end
      end
    end
  end

  // stage 1
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_tag <= '0;
    end else begin
      s1_tag <= tag;
    end
  end

  always_ff @(posedge clk) begin
    if (tag.valid) begin
      s1_sum <= row_sum;
    end
  end

  // accumulate over kernel rows
  always_comb begin
    for (int x = 0; x < conv_pkg::ROW_PIX; x++) begin
      acc_nxt[x] = s1_tag.first ? s1_sum[x] : acc[x] + s1_sum[x];
    end
  end

  // stage 2
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      psum_valid <= 1'b0;
    end else begin
      psum_valid <= s1_tag.valid && s1_tag.last;
    end
  end

  always_ff @(posedge clk) begin
    if (s1_tag.valid) begin
      acc <= acc_nxt;
      if (s1_tag.last) begin
        for (int x = 0; x < conv_pkg::ROW_PIX; x++) begin
          psum.sum[x] <= acc_nxt[x];  // full 3x3x4 result
        end
      end
    end
  end

endmodule

// File: logic/relu_quant.sv
`timescale 1ns/1ps

module relu_quant (
  input  logic                 clk,
  input  logic                 rst_n,
  input  conv_pkg::psum_row_t  psum,
  input  logic                 psum_valid,
  output conv_pkg::act_row_t   dout,
  output logic                 dout_valid
);

  conv_pkg::act_row_t act;

  // relu, shift, clamp per lane
  always_comb begin
    logic signed [conv_pkg::PSUM_W-1:0] v;
    logic        [conv_pkg::PSUM_W-1:0] sh;
    for (int x = 0; x < conv_pkg::ROW_PIX; x++) begin
      v  = $signed(psum.sum[x]);
      sh = v >>> conv_pkg::ACT_SHIFT;
      if (v < 0) begin
        act.pix[x] = '0;
      end else if (sh > 18'(255)) begin
        act.pix[x] = {conv_pkg::PIX_W{1'b1}};  // saturate
      end else begin
        act.pix[x] = sh[conv_pkg::PIX_W-1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dout_valid <= 1'b0;
    end else begin
      dout_valid <= psum_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (psum_valid) begin
      dout <= act;  // held until next row
    end
  end

endmodule

// File: logic/conv_layer_top.sv
`timescale 1ns/1ps

module conv_layer_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  din_valid,
  input  conv_pkg::pixel_row_t  din,
  input  logic                  frame_end,
  input  conv_pkg::kernel_t     weights,    // stable while busy
  output conv_pkg::act_row_t    dout,
  output logic                  dout_valid,
  output logic                  busy
);

  logic [conv_pkg::ROW_AW-1:0] rd_addr;
  conv_pkg::pixel_row_t        rd_data;
  logic                        frame_start;
  conv_pkg::padded_row_t       row_pad;
  conv_pkg::mac_tag_t          tag;
  conv_pkg::psum_row_t         psum;
  logic                        psum_valid;

  row_store u_row_store (
    .clk         (clk),
    .rst_n       (rst_n),
    .din_valid   (din_valid),
    .din         (din),
    .busy        (busy),
    .frame_start (frame_start),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data)
  );

  window_sequencer u_window_sequencer (
    .clk         (clk),
    .rst_n       (rst_n),
    .frame_end   (frame_end),
    .rd_data     (rd_data),
    .rd_addr     (rd_addr),
    .frame_start (frame_start),
    .busy        (busy),
    .row_pad     (row_pad),
    .tag         (tag)
  );

  conv_row_mac u_conv_row_mac (
    .clk        (clk),
    .rst_n      (rst_n),
    .row_pad    (row_pad),
    .tag        (tag),
    .weights    (weights),
    .psum       (psum),
    .psum_valid (psum_valid)
  );

  relu_quant u_relu_quant (
    .clk        (clk),
    .rst_n      (rst_n),
    .psum       (psum),
    .psum_valid (psum_valid),
    .dout       (dout),
    .dout_valid (dout_valid)
  );

endmodule

// File: tb/tb_conv_model.svh
`ifndef TB_CONV_MODEL_SVH
`define TB_CONV_MODEL_SVH

// expected activations of output row r from a whole input frame
function automatic conv_pkg::act_row_t conv_ref(
  input conv_pkg::pixel_row_t frame [conv_pkg::IN_ROWS],
  input conv_pkg::kernel_t    w,
  input int                   r
);
  conv_pkg::act_row_t res;
  int acc;
  int px;
  int wv;
  int xx;
  for (int x = 0; x < conv_pkg::ROW_PIX; x++) begin
    acc = 0;
    for (int k = 0; k < conv_pkg::K_ROWS; k++) begin
      for (int t = 0; t < conv_pkg::K_TAPS; t++) begin
        xx = x + t - 1;  // tap 1 is the centre pixel
        for (int c = 0; c < conv_pkg::N_CH; c++) begin
          px = 0;  // zero padding outside the row
          if (xx >= 0 && xx < conv_pkg::ROW_PIX) begin
            px = int'(frame[r+k].ch[c][xx]);
          end
          wv = int'($signed(w[k].tap[t][c]));
          acc += px * wv;
        end
      end
    end
    if (acc < 0) begin
      res.pix[x] = '0;  // relu
    end else if ((acc >> conv_pkg::ACT_SHIFT) > 255) begin
      res.pix[x] = 8'hff;
    end else begin
      res.pix[x] = 8'(acc >> conv_pkg::ACT_SHIFT);
    end
  end
  return res;
endfunction

`endif

// File: tb/tb_conv_layer.sv
`timescale 1ns/1ps

module tb_conv_layer;

  localparam int N_FRAMES    = 10;
  localparam int TIMEOUT_CYC = N_FRAMES * 40 + 200;
  localparam int FIRST_OUT   = 7;  // frame_end edge to first dout_valid
  localparam int BUSY_END    = conv_pkg::K_ROWS * (conv_pkg::OUT_ROWS - 1) + FIRST_OUT + 1;

  logic                 clk = 1'b0;
  logic                 rst_n;
  logic                 din_valid;
  conv_pkg::pixel_row_t din;
  logic                 frame_end;
  conv_pkg::kernel_t    weights;
  conv_pkg::act_row_t   dout;
  logic                 dout_valid;
  logic                 busy;

  conv_pkg::pixel_row_t frame_in [conv_pkg::IN_ROWS];
  conv_pkg::kernel_t    kernel_next;
  conv_pkg::act_row_t   exp_act [conv_pkg::OUT_ROWS];  // snapshot at frame start
  int seed = 32'haa76_e108;
  int cyc = 0;
  int edge0 = 0;
  int rows_seen = 0;
  int frames_done = 0;
  int mismatch_cnt = 0;
  int fail_cnt = 0;
  bit frame_active = 1'b0;

  `include "tb_conv_model.svh"

  conv_layer_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .din_valid  (din_valid),
    .din        (din),
    .frame_end  (frame_end),
    .weights    (weights),
    .dout       (dout),
    .dout_valid (dout_valid),
    .busy       (busy)
  );

  always #20 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  task automatic check_act(input string name, input conv_pkg::act_row_t got,
                           input conv_pkg::act_row_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  function automatic conv_pkg::pixel_row_t random_row();
    conv_pkg::pixel_row_t row;
    for (int c = 0; c < conv_pkg::N_CH; c++) begin
      for (int x = 0; x < conv_pkg::ROW_PIX; x++) begin
        row.ch[c][x] = 8'($random(seed));
      end
    end
    return row;
  endfunction

  task automatic fill_random_frame();
    for (int i = 0; i < conv_pkg::IN_ROWS; i++) begin
      frame_in[i] = random_row();
    end
  endtask

  task automatic fill_const_frame(input logic [7:0] p);
    for (int i = 0; i < conv_pkg::IN_ROWS; i++) begin
      frame_in[i].ch = {(conv_pkg::N_CH * conv_pkg::ROW_PIX){p}};
    end
  endtask

  task automatic set_kernel(input bit rnd, input logic [3:0] w);
    for (int k = 0; k < conv_pkg::K_ROWS; k++) begin
      for (int t = 0; t < conv_pkg::K_TAPS; t++) begin
        for (int c = 0; c < conv_pkg::N_CH; c++) begin
          kernel_next[k].tap[t][c] = rnd ? 4'($random(seed)) : w;
        end
      end
    end
  endtask

  // load weights, write all rows, pulse frame_end, wait until idle
  task automatic run_frame(input bit inject_busy, input int n_rows);
    @(posedge clk);
    weights <= kernel_next;
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk);
      if (i >= conv_pkg::IN_ROWS) begin
        frame_in[i - conv_pkg::IN_ROWS] = random_row();  // store wraps onto row 0
      end
      din_valid <= 1'b1;
      din       <= frame_in[i % conv_pkg::IN_ROWS];
    end
    @(posedge clk);
    din_valid <= 1'b0;
    frame_end <= 1'b1;
    @(posedge clk);
    frame_end <= 1'b0;
    if (inject_busy) begin
      for (int i = 0; i < 10; i++) begin
        @(posedge clk);
        din_valid <= 1'b1;  // must all be dropped
        din       <= random_row();
        frame_end <= (i % 3 == 0);
      end
      @(posedge clk);
      din_valid <= 1'b0;
      frame_end <= 1'b0;
    end
    @(negedge clk);
    while (busy) @(negedge clk);
  endtask

  // output checker sampling away from the active edge
  always @(negedge clk) begin : compare_outputs
    int ofs;
    logic exp_dv;
    logic exp_busy;
    ofs = cyc - edge0;
    if (rst_n && frame_active) begin
      exp_dv = (ofs >= FIRST_OUT) && ((ofs - FIRST_OUT) % conv_pkg::K_ROWS == 0)
               && ((ofs - FIRST_OUT) / conv_pkg::K_ROWS < conv_pkg::OUT_ROWS);
      exp_busy = (ofs >= 0) && (ofs < BUSY_END);
      check_bit("dout_valid", dout_valid, exp_dv);
      check_bit("busy", busy, exp_busy);
      if (dout_valid && rows_seen >= conv_pkg::OUT_ROWS) begin
        fail_cnt++;
        $display("error at %0t: more output rows than the frame has", $time);
      end else if (dout_valid) begin
        check_act($sformatf("dout row %0d", rows_seen), dout, exp_act[rows_seen]);
        rows_seen++;
      end
      if (ofs == BUSY_END) begin
        if (rows_seen != conv_pkg::OUT_ROWS) begin
          fail_cnt++;
          $display("error at %0t: too few rows, got %0d of %0d", $time, rows_seen,
                   conv_pkg::OUT_ROWS);
        end
        frame_active = 1'b0;
        frames_done++;
      end
    end else if (rst_n) begin
      if (dout_valid) begin
        fail_cnt++;
        $display("error at %0t: dout_valid seen while idle", $time);
      end
      if (busy) begin
        fail_cnt++;
        $display("error at %0t: busy high while idle", $time);
      end
    end
    if (rst_n && !frame_active && frame_end && !busy) begin
      frame_active = 1'b1;
      edge0        = cyc + 1;  // next rising edge samples frame_end
      rows_seen    = 0;
      for (int r = 0; r < conv_pkg::OUT_ROWS; r++) begin
        exp_act[r] = conv_ref(frame_in, weights, r);
      end
    end
  end

  initial begin
    wait (cyc >= TIMEOUT_CYC);
    $display("timeout after %0d cycles, the DUT did not finish its frames", cyc);
    $display("summary: %0d frames, %0d mismatches, %0d other errors", frames_done,
             mismatch_cnt, fail_cnt);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    rst_n     = 1'b0;
    din_valid = 1'b0;
    din       = '0;
    frame_end = 1'b0;
    weights   = '0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_bit("busy", busy, 1'b0);
    check_bit("dout_valid", dout_valid, 1'b0);
    repeat (8) @(posedge clk);  // idle with no output expected
    for (int f = 0; f < 4; f++) begin
      fill_random_frame();
      set_kernel(1'b1, 4'h0);
      run_frame(1'b0, conv_pkg::IN_ROWS);
    end
    fill_const_frame(8'hff);
    set_kernel(1'b0, 4'h7);  // saturates to 255
    run_frame(1'b0, conv_pkg::IN_ROWS);
    fill_random_frame();
    set_kernel(1'b0, 4'h8);  // all weights -8 so every lane clamps to 0
    run_frame(1'b0, conv_pkg::IN_ROWS);
    fill_random_frame();
    set_kernel(1'b1, 4'h0);
    run_frame(1'b1, conv_pkg::IN_ROWS);
    for (int f = 0; f < 3; f++) begin
      fill_random_frame();  // back to back with new weights each time
      set_kernel(1'b1, 4'h0);
      // surplus rows in the first frame leave the write pointer off row 0
      run_frame(1'b0, (f == 0) ? conv_pkg::IN_ROWS + 2 : conv_pkg::IN_ROWS);
    end
    repeat (4) @(posedge clk);
    if (frames_done != N_FRAMES) begin
      fail_cnt++;
      $display("error: %0d frames completed instead of %0d", frames_done, N_FRAMES);
    end
    $display("summary: %0d frames, %0d mismatches, %0d other errors", frames_done,
             mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+tb
logic/conv_pkg.sv
logic/row_store.sv
logic/window_sequencer.sv
logic/conv_row_mac.sv
logic/relu_quant.sv
logic/conv_layer_top.sv
tb/tb_conv_layer.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f src.f --top-module tb_conv_layer -o tb_sim
out=$(./obj_dir/tb_sim)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
